/* Makefile */
# Verilator build and run of the exec core testbench

VERILATOR ?= verilator
TOP       ?= execCoreTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

/* common/rvPkg.sv */
// rv64i exec core types
`include "rv_cfg.svh"

package rvPkg;

  typedef logic [`XLEN-1:0]     xword_t;   // operand, result, pc
  typedef logic [31:0]          instr_t;
  typedef logic [4:0]           regIdx_t;  // register number
  typedef logic [`AXI_AW-1:0]   axiAddr_t;
  typedef logic [`AXI_DW-1:0]   axiData_t;
  typedef logic [`AXI_DW/8-1:0] axiStrb_t;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0, ALU_SLL = 4'd1, ALU_SLT = 4'd2, ALU_SLTU = 4'd3,
    ALU_XOR = 4'd4, ALU_SRL = 4'd5, ALU_OR = 4'd6, ALU_AND = 4'd7,
    ALU_SUB = 4'd8, ALU_SRA = 4'd13, ALU_PASSB = 4'd15
  } aluOp_t;

  typedef enum logic [2:0] {
    IMM_I = 3'd0, IMM_U = 3'd1, IMM_S = 3'd2, IMM_B = 3'd3, IMM_J = 3'd4, IMM_R = 3'd5
  } immKind_t;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0, BR_JAL = 3'd1, BR_JALR = 3'd2,
    BR_EQ = 3'd4, BR_NE = 3'd5, BR_LT = 3'd6, BR_GE = 3'd7
  } branchKind_t;

  typedef enum logic [2:0] {
    MEM_W = 3'd0, MEM_B = 3'd1, MEM_H = 3'd2, MEM_D = 3'd3,  // D doubles as no access
    MEM_WU = 3'd4, MEM_BU = 3'd5, MEM_HU = 3'd6
  } memOp_t;

  typedef enum logic [1:0] {
    SRCB_REG = 2'd0, SRCB_IMM = 2'd1, SRCB_FOUR = 2'd2
  } srcB_t;

  typedef struct packed {
    logic        srcAIsReg;  // 0 pc, 1 rs1
    srcB_t       srcBSel;
    immKind_t    immKind;
    aluOp_t      aluOp;
    branchKind_t branch;
    memOp_t      memOp;
    logic        memRead;
    logic        memWrite;
    logic        wen;
    logic        ebreak;
    logic        illegal;
  } ctrl_t;

  typedef struct packed {
    logic   valid;
    xword_t pc;
    instr_t instr;
    xword_t rs1Val;
    xword_t rs2Val;
  } issue_t;

  typedef struct packed {
    logic    valid;
    xword_t  pc;
    xword_t  nextPc;
    xword_t  wbData;     // alu result or load/store address
    xword_t  storeData;
    regIdx_t rd;
    logic    wen;
    memOp_t  memOp;
    logic    memRead;
    logic    memWrite;
    logic    trap;       // ebreak seen
    logic    illegal;
  } result_t;

endpackage

/* common/rv_cfg.svh */
// exec core configuration
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

`define XLEN   64  // data path width
`define AXI_AW 4   // register window address bits
`define AXI_DW 32  // register bus data width

// register map
`define REG_CTRL    4'h0  // bit0 enable, bit1 clear halt
`define REG_STATUS  4'h4  // bit0 halted, bit1 illegal
`define REG_RETIRED 4'h8  // low word of retired count

`endif

/* rtl/decode/immGen.sv */
// immediate generator
`timescale 1ns/100ps

module immGen import rvPkg::*; (
  input  instr_t   instr,
  input  immKind_t immKind,
  output xword_t   imm
);

  logic sgn;

  assign sgn = instr[31];  // every format signs from bit 31

  always_comb begin
    case (immKind)
      IMM_I: imm = {{52{sgn}}, instr[31:20]};
      IMM_S: imm = {{52{sgn}}, instr[31:25], instr[11:7]};
      IMM_B: imm = {{52{sgn}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      IMM_U: imm = {{32{sgn}}, instr[31:12], 12'b0};
      IMM_J: imm = {{44{sgn}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;  // R kind, no immediate
    endcase
  end

endmodule

/* rtl/decode/instrDecoder.sv */
// rv64i instruction decoder
`timescale 1ns/100ps

module instrDecoder import rvPkg::*; (
  input  instr_t instr,
  output ctrl_t  ctrl
);

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [6:0] opcode;
  logic [2:0] func3;
  logic [6:0] func7;

  assign opcode = instr[6:0];
  assign func3  = instr[14:12];
  assign func7  = instr[31:25];

  // shared by OP and OP-IMM, alt picks sub or sra
  function automatic aluOp_t aluOpOf(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl           = '0;
    ctrl.srcAIsReg = 1'b1;
    ctrl.srcBSel   = SRCB_REG;
    ctrl.immKind   = IMM_R;
    ctrl.aluOp     = ALU_ADD;
    ctrl.branch    = BR_NONE;
    ctrl.memOp     = MEM_D;  // no access
    case (opcode)
      OPC_LUI: begin
        ctrl.srcBSel = SRCB_IMM;
        ctrl.immKind = IMM_U;
        ctrl.aluOp   = ALU_PASSB;  // imm straight through
        ctrl.wen     = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl.srcAIsReg = 1'b0;
        ctrl.srcBSel   = SRCB_IMM;
        ctrl.immKind   = IMM_U;
        ctrl.wen       = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        ctrl.srcAIsReg = 1'b0;  // link = pc + 4 via alu
        ctrl.srcBSel   = SRCB_FOUR;
        ctrl.immKind   = (opcode == OPC_JAL) ? IMM_J : IMM_I;
        ctrl.branch    = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
        ctrl.wen       = 1'b1;
      end
      OPC_OPIMM: begin
        ctrl.srcBSel = SRCB_IMM;
        ctrl.immKind = IMM_I;
        ctrl.aluOp   = aluOpOf(func3, (func3 == 3'b101) & instr[30]);  // only srai
        ctrl.wen     = 1'b1;
      end
      OPC_OP: begin
        ctrl.aluOp = aluOpOf(func3, (func3 == 3'b000) ? (func7 == 7'b0100000) : instr[30]);
        ctrl.wen   = 1'b1;
      end
      OPC_BRANCH: begin
        ctrl.immKind = IMM_B;
        case (func3)
          3'b000: begin ctrl.aluOp = ALU_SUB;  ctrl.branch = BR_EQ; end
          3'b001: begin ctrl.aluOp = ALU_SUB;  ctrl.branch = BR_NE; end
          3'b100: begin ctrl.aluOp = ALU_SLT;  ctrl.branch = BR_LT; end
          3'b101: begin ctrl.aluOp = ALU_SLT;  ctrl.branch = BR_GE; end
          3'b110: begin ctrl.aluOp = ALU_SLTU; ctrl.branch = BR_LT; end  // bltu
          3'b111: begin ctrl.aluOp = ALU_SLTU; ctrl.branch = BR_GE; end  // bgeu
          default: ctrl.illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        ctrl.srcBSel = SRCB_IMM;  // address = rs1 + imm
        ctrl.immKind = IMM_I;
        ctrl.memRead = 1'b1;
        ctrl.wen     = 1'b1;
        case (func3)
          3'b000:  ctrl.memOp = MEM_B;
          3'b001:  ctrl.memOp = MEM_H;
          3'b010:  ctrl.memOp = MEM_W;
          3'b011:  ctrl.memOp = MEM_D;
          3'b100:  ctrl.memOp = MEM_BU;
          3'b101:  ctrl.memOp = MEM_HU;
          3'b110:  ctrl.memOp = MEM_WU;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      OPC_STORE: begin
        ctrl.srcBSel  = SRCB_IMM;
        ctrl.immKind  = IMM_S;
        ctrl.memWrite = 1'b1;
        case (func3)
          3'b000:  ctrl.memOp = MEM_B;
          3'b001:  ctrl.memOp = MEM_H;
          3'b010:  ctrl.memOp = MEM_W;
          3'b011:  ctrl.memOp = MEM_D;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        ctrl.immKind = IMM_I;
        if (instr[31:20] == 12'h001 && instr[19:7] == '0) ctrl.ebreak = 1'b1;
        else ctrl.illegal = 1'b1;  // ecall and csr ops not handled
      end
      default: ctrl.illegal = 1'b1;
    endcase
    if (ctrl.illegal) begin  // no side effects from a bad instr
      ctrl.wen      = 1'b0;
      ctrl.memRead  = 1'b0;
      ctrl.memWrite = 1'b0;
    end
  end

endmodule

/* rtl/exec/alu.sv */
// 64-bit integer alu
`timescale 1ns/100ps

module alu import rvPkg::*; (
  input  xword_t a,
  input  xword_t b,
  input  aluOp_t op,
  output xword_t y,
  output logic   zero
);

  logic [5:0] shamt;
  logic       ltSigned;
  logic       ltUnsigned;

  assign shamt      = b[5:0];  // rv64 uses six shift bits
  assign ltSigned   = $signed(a) < $signed(b);
  assign ltUnsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:   y = a + b;
      ALU_SUB:   y = a - b;
      ALU_SLL:   y = a << shamt;
      ALU_SRL:   y = a >> shamt;
      ALU_SRA:   y = $signed(a) >>> shamt;
      ALU_SLT:   y = {{63{1'b0}}, ltSigned};
      ALU_SLTU:  y = {{63{1'b0}}, ltUnsigned};
      ALU_XOR:   y = a ^ b;
      ALU_OR:    y = a | b;
      ALU_AND:   y = a & b;
      ALU_PASSB: y = b;  // lui
      default:   y = '0;
    endcase
  end

  // beq/bne run SUB, so zero means equal operands
  assign zero = (y == '0);

endmodule

/* rtl/exec/branchUnit.sv */
// branch resolve and next pc
`timescale 1ns/100ps

module branchUnit import rvPkg::*; (
  input  branchKind_t kind,
  input  xword_t      pc,
  input  xword_t      imm,
  input  xword_t      rs1Val,
  input  xword_t      aluY,
  input  logic        aluZero,
  output xword_t      nextPc,
  output logic        taken
);

  xword_t jalrTarget;

  assign jalrTarget = (rs1Val + imm) & ~xword_t'(1);  // bit 0 dropped

  always_comb begin
    case (kind)
      BR_JAL, BR_JALR: taken = 1'b1;
      BR_EQ:           taken = aluZero;
      BR_NE:           taken = ~aluZero;
      BR_LT:           taken = aluY[0];   // slt/sltu result
      BR_GE:           taken = ~aluY[0];
      default:         taken = 1'b0;
    endcase
  end

  assign nextPc = (kind == BR_JALR) ? jalrTarget :
                  taken             ? pc + imm   : pc + 64'd4;

endmodule

/* rtl/exec/execStage.sv */
// execute stage with result register
`timescale 1ns/100ps

module execStage import rvPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  issue_t  issue,
  input  ctrl_t   ctrl,
  input  xword_t  imm,
  input  logic    run,
  output result_t result
);

  xword_t  opA, opB;
  xword_t  aluY;
  logic    aluZero;
  xword_t  nextPc;
  logic    accept;
  result_t resD;

  assign opA    = ctrl.srcAIsReg ? issue.rs1Val : issue.pc;
  assign accept = issue.valid & run;  // dropped when stopped

  always_comb begin
    case (ctrl.srcBSel)
      SRCB_REG:  opB = issue.rs2Val;
      SRCB_IMM:  opB = imm;
      SRCB_FOUR: opB = 64'd4;  // link value
      default:   opB = '0;
    endcase
  end

  alu u_alu (
    .a    (opA),
    .b    (opB),
    .op   (ctrl.aluOp),
    .y    (aluY),
    .zero (aluZero)
  );

  branchUnit u_branch (
    .kind    (ctrl.branch),
    .pc      (issue.pc),
    .imm     (imm),
    .rs1Val  (issue.rs1Val),
    .aluY    (aluY),
    .aluZero (aluZero),
    .nextPc  (nextPc),
    .taken   ()  // folded into nextPc already
  );

  always_comb begin
    resD.valid     = accept;
    resD.pc        = issue.pc;
    resD.nextPc    = nextPc;
    resD.wbData    = aluY;
    resD.storeData = issue.rs2Val;
    resD.rd        = issue.instr[11:7];
    resD.wen       = ctrl.wen;
    resD.memOp     = ctrl.memOp;
    resD.memRead   = ctrl.memRead;
    resD.memWrite  = ctrl.memWrite;
    resD.trap      = ctrl.ebreak;
    resD.illegal   = ctrl.illegal;
  end

  always_ff @(posedge clk) begin
    if (accept) result <= resD;  // payload held between instrs
    if (rst) result.valid <= 1'b0;
    else result.valid <= accept;
  end

endmodule

/* rtl/execCoreTop.sv */
// decode and execute core top
`timescale 1ns/100ps

module execCoreTop import rvPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  issue_t     issue,
  output result_t    result,
  input  axiAddr_t   awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axiData_t   wdata,
  input  axiStrb_t   wstrb,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  input  axiAddr_t   araddr,
  input  logic       arvalid,
  output logic       arready,
  output axiData_t   rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready
);

  ctrl_t  ctrl;
  xword_t imm;
  logic   run;  // enable and not halted

  instrDecoder u_dec (
    .instr (issue.instr),
    .ctrl  (ctrl)
  );

  immGen u_imm (
    .instr   (issue.instr),
    .immKind (ctrl.immKind),
    .imm     (imm)
  );

  execStage u_exec (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .ctrl   (ctrl),
    .imm    (imm),
    .run    (run),
    .result (result)
  );

  execCtrlRegs u_regs (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .result  (result),
    .run     (run)
  );

endmodule

/* rtl/execCtrlRegs.sv */
// exec control and status registers
`timescale 1ns/100ps
`include "rv_cfg.svh"

module execCtrlRegs import rvPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  axiAddr_t awaddr,
  input  logic     awvalid,
  output logic     awready,
  input  axiData_t wdata,
  input  axiStrb_t wstrb,
  input  logic     wvalid,
  output logic     wready,
  output logic [1:0] bresp,
  output logic     bvalid,
  input  logic     bready,
  input  axiAddr_t araddr,
  input  logic     arvalid,
  output logic     arready,
  output axiData_t rdata,
  output logic [1:0] rresp,
  output logic     rvalid,
  input  logic     rready,
  input  result_t  result,
  output logic     run
);

  logic     wrAck, rdAck;
  logic     wrFire, rdFire;
  logic     enable, halted, illegalSeen;
  axiData_t retiredCnt;  // wraps at bus width
  axiData_t rdMux;

  assign awready = wrAck;  // aw and w accepted together
  assign wready  = wrAck;
  assign arready = rdAck;
  assign bresp   = 2'b00;  // always OKAY
  assign rresp   = 2'b00;
  assign wrFire  = wrAck & awvalid & wvalid;
  assign rdFire  = rdAck & arvalid;
  assign run     = enable & ~halted;

  // write channel
  always_ff @(posedge clk) begin
    if (rst) begin
      wrAck  <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      wrAck <= awvalid & wvalid & ~wrAck & ~bvalid;  // one-cycle pulse
      if (wrFire) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
    end
  end

  // read channel
  always_ff @(posedge clk) begin
    if (rst) begin
      rdAck  <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      rdAck <= arvalid & ~rdAck & ~rvalid;  // wait until response drained
      if (rdFire) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rdFire) rdata <= rdMux;
  end

  always_comb begin
    rdMux = '0;  // unmapped reads zero
    case (araddr)
      `REG_CTRL:    rdMux[0] = enable;
      `REG_STATUS:  rdMux[1:0] = {illegalSeen, halted};
      `REG_RETIRED: rdMux = retiredCnt;
      default:      rdMux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      enable      <= 1'b0;
      halted      <= 1'b0;
      illegalSeen <= 1'b0;
      retiredCnt  <= '0;
    end else begin
      if (wrFire && awaddr == `REG_CTRL && wstrb[0]) begin
        enable <= wdata[0];
        if (wdata[1]) begin  // resume after halt
          halted      <= 1'b0;
          illegalSeen <= 1'b0;
        end
      end
      if (result.valid) begin  // set beats a same-cycle clear
        retiredCnt <= retiredCnt + 1'b1;
        if (result.trap || result.illegal) halted <= 1'b1;
        if (result.illegal) illegalSeen <= 1'b1;
      end
    end
  end

endmodule

/* sim/execCoreTb.sv */
// exec core testbench
`timescale 1ns/100ps
`include "rv_cfg.svh"

module execCoreTb import rvPkg::*; ();

  localparam int AXI_WAIT = 32;  // cycles before an AXI wait gives up
  localparam int M_RND = 0;      // operand modes
  localparam int M_EQ  = 1;
  localparam int M_LT  = 2;      // rs1 < rs2 signed and unsigned
  localparam int M_GT  = 3;
  localparam int M_NEG = 4;      // rs1 negative, rs2 positive

  logic     clk;
  logic     rst;
  issue_t   issue;
  result_t  result;
  axiAddr_t awaddr, araddr;
  axiData_t wdata, rdata;
  axiStrb_t wstrb;
  logic     awvalid, awready, wvalid, wready, bvalid, bready;
  logic     arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;

  int          errors = 0;
  int          checks = 0;
  int          resultsSeen = 0;
  logic [31:0] lcgState = 32'd83165;

  string   tName[$];  // stimulus table
  instr_t  tInstr[$];
  xword_t  tPc[$];
  xword_t  tA[$];
  xword_t  tB[$];
  result_t tExp[$];   // expected from the model

  execCoreTop u_dut (
    .clk(clk), .rst(rst), .issue(issue), .result(result),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  always @(negedge clk) begin
    if (!rst && result.valid) resultsSeen++;  // counted mid-cycle away from the edges
  end

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  // every encoder uses rd x5 with rs1 x6 and rs2 x7
  function automatic instr_t encR(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd7, 5'd6, f3, 5'd5, 7'h33};
  endfunction

  function automatic instr_t encI(input logic [11:0] imm, input logic [2:0] f3,
                                  input logic [6:0] opc);
    return {imm, 5'd6, f3, 5'd5, opc};
  endfunction

  function automatic instr_t encS(input logic [11:0] imm, input logic [2:0] f3);
    return {imm[11:5], 5'd7, 5'd6, f3, imm[4:0], 7'h23};
  endfunction

  function automatic instr_t encB(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd7, 5'd6, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic instr_t encU(input logic [19:0] imm, input logic [6:0] opc);
    return {imm, 5'd5, opc};
  endfunction

  function automatic instr_t encJ(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd5, 7'h6f};
  endfunction

  // rv64i integer op semantics
  function automatic xword_t aluModel(input logic [2:0] f3, input logic alt,
                                      input xword_t a, input xword_t b);
    xword_t y;
    case (f3)
      3'd0: y = alt ? a - b : a + b;
      3'd1: y = a << b[5:0];
      3'd2: y = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'd3: y = (a < b) ? 64'd1 : 64'd0;
      3'd4: y = a ^ b;
      3'd5: begin
        if (alt) y = $signed(a) >>> b[5:0];
        else y = a >> b[5:0];
      end
      3'd6: y = a | b;
      default: y = a & b;
    endcase
    return y;
  endfunction

  function automatic result_t expectResult(input instr_t ins, input xword_t pc,
                                           input xword_t a, input xword_t b);
    result_t    r;
    xword_t     immI, immS, immB, immU, immJ;
    logic [2:0] f3;
    logic       taken;
    f3   = ins[14:12];
    immI = {{52{ins[31]}}, ins[31:20]};
    immS = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    immB = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    immU = {{32{ins[31]}}, ins[31:12], 12'h000};
    immJ = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    taken = 1'b0;
    r = '0;
    r.valid     = 1'b1;
    r.pc        = pc;
    r.nextPc    = pc + 64'd4;  // fall through
    r.storeData = b;
    r.rd        = ins[11:7];
    r.memOp     = MEM_D;       // no access
    case (ins[6:0])
      7'h37: r.wbData = immU;  // lui
      7'h17: r.wbData = pc + immU;
      7'h6f: begin
        r.wbData = pc + 64'd4;
        r.nextPc = pc + immJ;
      end
      7'h67: begin
        r.wbData = pc + 64'd4;
        r.nextPc = (a + immI) & ~64'd1;
      end
      7'h13: r.wbData = aluModel(f3, (f3 == 3'd5) && ins[30], a, immI);
      7'h33: r.wbData = aluModel(f3, ins[30], a, b);
      7'h63: begin
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          3'd7: taken = a >= b;
          default: r.illegal = 1'b1;
        endcase
        if (taken) r.nextPc = pc + immB;
      end
      7'h03: begin
        r.wbData  = a + immI;  // load address
        r.memRead = 1'b1;
        case (f3)
          3'd0: r.memOp = MEM_B;
          3'd1: r.memOp = MEM_H;
          3'd2: r.memOp = MEM_W;
          3'd3: r.memOp = MEM_D;
          3'd4: r.memOp = MEM_BU;
          3'd5: r.memOp = MEM_HU;
          3'd6: r.memOp = MEM_WU;
          default: r.illegal = 1'b1;
        endcase
      end
      7'h23: begin
        r.wbData   = a + immS;  // store address
        r.memWrite = 1'b1;
        case (f3)
          3'd0: r.memOp = MEM_B;
          3'd1: r.memOp = MEM_H;
          3'd2: r.memOp = MEM_W;
          3'd3: r.memOp = MEM_D;
          default: r.illegal = 1'b1;
        endcase
      end
      7'h73: begin
        if (ins == 32'h0010_0073) r.trap = 1'b1;  // ebreak
        else r.illegal = 1'b1;
      end
      default: r.illegal = 1'b1;
    endcase
    r.wen = !r.illegal && ins[6:0] inside {7'h37, 7'h17, 7'h6f, 7'h67, 7'h13, 7'h33, 7'h03};
    if (r.illegal) begin
      r.memRead  = 1'b0;
      r.memWrite = 1'b0;
    end
    return r;
  endfunction

  task automatic compareVal(input string name, input string field,
                            input logic [63:0] expVal, input logic [63:0] actVal);
    checks++;
    if (expVal !== actVal) begin
      errors++;
      $display("** Error: %s %s expected %h actual %h", name, field, expVal, actVal);
    end
  endtask

  task automatic verifyResult(input string name, input result_t exp);
    if (result.valid !== 1'b1) begin
      errors++;
      $display("%s: no valid result in the cycle after issue", name);
    end else begin
      compareVal(name, "pc", exp.pc, result.pc);
      compareVal(name, "nextPc", exp.nextPc, result.nextPc);
      compareVal(name, "rd", 64'(exp.rd), 64'(result.rd));
      compareVal(name, "wen", 64'(exp.wen), 64'(result.wen));
      compareVal(name, "memOp", 64'(exp.memOp), 64'(result.memOp));
      compareVal(name, "memRead", 64'(exp.memRead), 64'(result.memRead));
      compareVal(name, "memWrite", 64'(exp.memWrite), 64'(result.memWrite));
      compareVal(name, "trap", 64'(exp.trap), 64'(result.trap));
      compareVal(name, "illegal", 64'(exp.illegal), 64'(result.illegal));
      compareVal(name, "storeData", exp.storeData, result.storeData);
      if (exp.wen || exp.memRead || exp.memWrite)  // branches leave wbData open
        compareVal(name, "wbData", exp.wbData, result.wbData);
    end
  endtask

  task automatic pickOps(input int mode, output xword_t a, output xword_t b);
    xword_t r1, r2;
    r1 = {lcgNext(), lcgNext()};
    r2 = {lcgNext(), lcgNext()};
    case (mode)
      M_EQ: begin
        a = r1;
        b = r1;
      end
      M_LT: begin
        a = {2'b00, r1[61:0]};
        b = a + {48'd0, r2[15:0]} + 64'd1;
      end
      M_GT: begin
        b = {2'b00, r1[61:0]};
        a = b + {48'd0, r2[15:0]} + 64'd1;
      end
      M_NEG: begin
        a = {1'b1, r1[62:0]};
        b = {1'b0, r2[62:0]};
      end
      default: begin
        a = r1;
        b = r2;
      end
    endcase
  endtask

  task automatic addTest(input string name, input instr_t ins, input int mode);
    xword_t a, b, pc;
    pc = 64'h0000_0040_8000_1000 + 64'(tName.size()) * 64'd4;
    pickOps(mode, a, b);
    tName.push_back(name);
    tInstr.push_back(ins);
    tPc.push_back(pc);
    tA.push_back(a);
    tB.push_back(b);
    tExp.push_back(expectResult(ins, pc, a, b));
  endtask

  task automatic buildTable();
    logic [2:0] brF3 [6];
    brF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    addTest("add", encR(7'h00, 3'd0), M_RND);
    addTest("sub", encR(7'h20, 3'd0), M_RND);
    addTest("sll", encR(7'h00, 3'd1), M_RND);
    addTest("slt", encR(7'h00, 3'd2), M_NEG);
    addTest("sltu", encR(7'h00, 3'd3), M_NEG);
    addTest("xor", encR(7'h00, 3'd4), M_RND);
    addTest("srl", encR(7'h00, 3'd5), M_NEG);
    addTest("sra", encR(7'h20, 3'd5), M_NEG);
    addTest("or", encR(7'h00, 3'd6), M_RND);
    addTest("and", encR(7'h00, 3'd7), M_RND);
    addTest("addi", encI(12'hFFB, 3'd0, 7'h13), M_RND);
    addTest("slti", encI(12'h123, 3'd2, 7'h13), M_RND);
    addTest("sltiu", encI(12'h800, 3'd3, 7'h13), M_RND);
    addTest("xori", encI(12'hF0F, 3'd4, 7'h13), M_RND);
    addTest("ori", encI(12'h5A5, 3'd6, 7'h13), M_RND);
    addTest("andi", encI(12'h0FF, 3'd7, 7'h13), M_RND);
    addTest("slli", encI({6'h00, 6'd13}, 3'd1, 7'h13), M_RND);
    addTest("srli", encI({6'h00, 6'd40}, 3'd5, 7'h13), M_NEG);
    addTest("srai", encI({6'h10, 6'd33}, 3'd5, 7'h13), M_NEG);
    addTest("lui", encU(20'hABCDE, 7'h37), M_RND);
    addTest("auipc", encU(20'h12345, 7'h17), M_RND);
    addTest("jal fwd", encJ(21'h000804), M_RND);
    addTest("jal back", encJ(21'h1FFFF0), M_RND);
    addTest("jalr", encI(12'h7FF, 3'd0, 7'h67), M_RND);  // odd sum half the time
    foreach (brF3[k])
      for (int m = M_EQ; m <= M_NEG; m++)
        addTest($sformatf("branch f3=%0d mode=%0d", brF3[k], m),
                encB(m[0] ? 13'h1F0C : 13'h0040, brF3[k]), m);
    for (int f = 0; f < 7; f++)
      addTest($sformatf("load f3=%0d", f), encI(12'h010, 3'(f), 7'h03), M_RND);
    for (int f = 0; f < 4; f++)
      addTest($sformatf("store f3=%0d", f), encS(12'hFF8, 3'(f)), M_RND);
  endtask

  // call a little after a rising edge
  task automatic driveIssue(input instr_t ins, input xword_t pc,
                            input xword_t a, input xword_t b);
    issue.valid  = 1'b1;
    issue.pc     = pc;
    issue.instr  = ins;
    issue.rs1Val = a;
    issue.rs2Val = b;
  endtask

  task automatic axiWrite(input axiAddr_t addr, input axiData_t data);
    int waitCnt;
    @(posedge clk);
    #1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    waitCnt = 0;
    while (!awready && waitCnt < AXI_WAIT) begin
      @(posedge clk);
      #1;
      waitCnt++;
    end
    if (!awready) begin
      errors++;
      $display("AXI write to offset %h was never accepted", addr);
    end
    @(posedge clk);  // handshake edge
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    waitCnt = 0;
    while (!bvalid && waitCnt < AXI_WAIT) begin
      @(posedge clk);
      #1;
      waitCnt++;
    end
    if (!bvalid) begin
      errors++;
      $display("AXI write to offset %h got no write response", addr);
    end else compareVal("axi write", "bresp", 64'd0, 64'(bresp));
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axiRead(input axiAddr_t addr, output axiData_t data);
    int waitCnt;
    @(posedge clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    waitCnt = 0;
    data    = '0;
    while (!arready && waitCnt < AXI_WAIT) begin
      @(posedge clk);
      #1;
      waitCnt++;
    end
    if (!arready) begin
      errors++;
      $display("AXI read of offset %h was never accepted", addr);
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    waitCnt = 0;
    while (!rvalid && waitCnt < AXI_WAIT) begin
      @(posedge clk);
      #1;
      waitCnt++;
    end
    if (!rvalid) begin
      errors++;
      $display("AXI read of offset %h got no read data", addr);
    end else begin
      data = rdata;
      compareVal("axi read", "rresp", 64'd0, 64'(rresp));
    end
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // back to back issue with each result checked one cycle later
  task automatic applyTable();
    for (int i = 0; i <= tName.size(); i++) begin
      @(posedge clk);
      #1;
      if (i > 0) verifyResult(tName[i-1], tExp[i-1]);
      if (i < tName.size()) driveIssue(tInstr[i], tPc[i], tA[i], tB[i]);
      else issue.valid = 1'b0;
    end
  endtask

  task automatic haltAndResume();
    xword_t   a, b, pc;
    instr_t   addi, xori;
    axiData_t rd;
    pc   = 64'h0000_0040_8000_2000;
    addi = encI(12'h011, 3'd0, 7'h13);
    xori = encI(12'h0F0, 3'd4, 7'h13);
    pickOps(M_RND, a, b);
    @(posedge clk);
    #1;
    driveIssue(32'h0010_0073, pc, a, b);
    @(posedge clk);
    #1;
    verifyResult("ebreak", expectResult(32'h0010_0073, pc, a, b));
    driveIssue(addi, pc + 64'd4, a, b);  // still runs
    @(posedge clk);
    #1;
    verifyResult("issue after ebreak", expectResult(addi, pc + 64'd4, a, b));
    driveIssue(xori, pc + 64'd8, a, b);  // should be dropped
    @(posedge clk);
    #1;
    issue.valid = 1'b0;
    if (result.valid !== 1'b0) begin
      errors++;
      $display("instruction issued two cycles after ebreak was executed while halted");
    end
    axiRead(`REG_STATUS, rd);
    compareVal("status after ebreak", "STATUS", 64'h1, 64'(rd));
    axiRead(`REG_RETIRED, rd);
    // whole table plus the ebreak and the issue right after it
    compareVal("retired count", "RETIRED", 64'(tName.size() + 2), 64'(rd));
    axiWrite(`REG_CTRL, 32'h3);  // keep enable, clear halt
    axiRead(`REG_STATUS, rd);
    compareVal("status after resume", "STATUS", 64'h0, 64'(rd));
    @(posedge clk);
    #1;
    driveIssue(addi, pc + 64'hC, a, b);
    @(posedge clk);
    #1;
    issue.valid = 1'b0;
    verifyResult("issue after resume", expectResult(addi, pc + 64'hC, a, b));
  endtask

  task automatic illegalOpcode();
    xword_t   a, b, pc;
    axiData_t rd;
    pc = 64'h0000_0040_8000_3000;
    pickOps(M_RND, a, b);
    @(posedge clk);
    #1;
    driveIssue(32'h0000_02FF, pc, a, b);  // opcode 7f, rd x5
    @(posedge clk);
    #1;
    issue.valid = 1'b0;
    verifyResult("unknown opcode", expectResult(32'h0000_02FF, pc, a, b));
    axiRead(`REG_STATUS, rd);
    compareVal("status after illegal", "STATUS", 64'h3, 64'(rd));
  endtask

  initial begin
    int budget;
    #1;  // table is built at time 0
    budget = tName.size() * 20 + 16 + 400;
    repeat (budget) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", budget);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    axiData_t rd;
    rst     = 1'b1;
    issue   = '0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    buildTable();
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    axiWrite(`REG_CTRL, 32'h1);
    axiRead(`REG_CTRL, rd);
    compareVal("enable readback", "CTRL", 64'h1, 64'(rd));
    applyTable();
    haltAndResume();
    illegalOpcode();
    $display("errors: %0d  checks: %0d  results: %0d", errors, checks, resultsSeen);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sim/execCore_sva.sv */
// exec core assertions
`timescale 1ns/100ps

module execCore_sva (
  input logic clk,
  input logic rst,
  input logic accept,    // issue valid and run
  input logic resValid,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready
);

  resultNeedsIssue: assert property (@(posedge clk) disable iff (rst)
    resValid |-> $past(accept))
    else $error("result valid without an accepted issue on the cycle before");

  bvalidHolds: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  rvalidHolds: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  // write taken only with both channels presenting data
  awWithW: assert property (@(posedge clk) disable iff (rst)
    awready |-> wready && awvalid && wvalid)
    else $error("awready high without wready or without both write valids");

endmodule

// stage side with AXI inputs tied off
bind execStage execCore_sva u_stageSva (
  .clk(clk), .rst(rst), .accept(accept), .resValid(result.valid),
  .awvalid(1'b0), .awready(1'b0), .wvalid(1'b0), .wready(1'b0),
  .bvalid(1'b0), .bready(1'b0), .rvalid(1'b0), .rready(1'b0)
);

// register side with result inputs tied off
bind execCtrlRegs execCore_sva u_regsSva (
  .clk(clk), .rst(rst), .accept(1'b0), .resValid(1'b0),
  .awvalid(awvalid), .awready(awready), .wvalid(wvalid), .wready(wready),
  .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready)
);

/* verilog.f */
+incdir+common
common/rvPkg.sv
rtl/decode/instrDecoder.sv
rtl/decode/immGen.sv
rtl/exec/alu.sv
rtl/exec/branchUnit.sv
rtl/exec/execStage.sv
rtl/execCtrlRegs.sv
rtl/execCoreTop.sv
sim/execCore_sva.sv
sim/execCoreTb.sv
